/* bench/msx_tb_vectors.svh */
`ifndef MSX_TB_VECTORS_SVH
`define MSX_TB_VECTORS_SVH

typedef enum logic [2:0] {
   op_io_wr, op_io_rd, op_mem_wr, op_mem_rd, op_fetch, op_audio, op_audio_rnd
} vec_op_t;

// Columns: operation, address (ext_sound for audio rows), data (bit 0 is tape_in
// for audio rows), expected byte for I/O reads
typedef struct packed {
   vec_op_t     op;
   logic [15:0] addr;
   logic [7:0]  data;
   logic [7:0]  exp;
} vec_t;

localparam int num_vecs = 33;

localparam vec_t vectors [num_vecs] = '{
   '{op_io_rd,     16'h00A8, 8'h00, 8'h00},
   '{op_mem_rd,    16'h0010, 8'h00, 8'h00},
   // Page 1 on RAM slot, page 2 on ROM slot, page 3 empty
   '{op_io_wr,     16'h00A8, 8'hE4, 8'h00},
   '{op_io_rd,     16'h00A8, 8'h00, 8'hE4},
   '{op_mem_wr,    16'h4123, 8'h00, 8'h00},
   '{op_mem_rd,    16'h4123, 8'h00, 8'h00},
   '{op_mem_rd,    16'h8010, 8'h00, 8'h00},
   '{op_mem_wr,    16'h8010, 8'h00, 8'h00},
   '{op_mem_rd,    16'h8010, 8'h00, 8'h00},
   '{op_mem_rd,    16'hC000, 8'h00, 8'h00},
   '{op_fetch,     16'h4123, 8'h00, 8'h00},
   '{op_fetch,     16'h9ABC, 8'h00, 8'h00},
   // Keyboard rows 3 and 10
   '{op_io_wr,     16'h00AA, 8'h03, 8'h00},
   '{op_io_rd,     16'h00A9, 8'h00, 8'hCC},
   '{op_io_wr,     16'h00AA, 8'h1A, 8'h00},
   '{op_io_rd,     16'h00A9, 8'h00, 8'h55},
   '{op_io_rd,     16'h00AA, 8'h00, 8'h1A},
   // Every page on slot 1, aliases of earlier RAM bytes
   '{op_io_wr,     16'h00A8, 8'h55, 8'h00},
   '{op_fetch,     16'h0123, 8'h00, 8'h00},
   '{op_mem_wr,    16'h0200, 8'h00, 8'h00},
   '{op_mem_rd,    16'hC200, 8'h00, 8'h00},
   // Motor still on here
   '{op_audio,     16'h3EFF, 8'h01, 8'h00},
   '{op_io_wr,     16'h00AA, 8'h00, 8'h00},
   '{op_audio,     16'h3EFF, 8'h01, 8'h00},
   '{op_audio,     16'h3F00, 8'h01, 8'h00},
   '{op_audio,     16'h7FFF, 8'h00, 8'h00},
   '{op_io_wr,     16'h00AA, 8'h80, 8'h00},
   '{op_audio,     16'hC000, 8'h01, 8'h00},
   '{op_audio,     16'hBE00, 8'h00, 8'h00},
   '{op_audio,     16'h8000, 8'h01, 8'h00},
   '{op_io_wr,     16'h00AA, 8'h90, 8'h00},
   '{op_audio_rnd, 16'h0000, 8'h01, 8'h00},
   '{op_audio_rnd, 16'h0000, 8'h00, 8'h00}
};

`endif

/* bench/msx_top_tb.sv */
`timescale 1ns/1ps

module msx_top_tb;

   `include "msx_tb_vectors.svh"

   localparam int          ce_period_clks = 2;
   localparam int          timeout_cycles = num_vecs * 8 + 200;
   localparam int unsigned mem_bytes      = 1 << msx_bus_pkg::ram_addr_w;

   logic                      clock_bus;
   logic                      rst_n;
   msx_bus_pkg::cpu_pins_t    cpu;
   logic                      cpu_ce;
   msx_config_pkg::slot_cfg_t slot_layout [4];
   logic [7:0]                kbd_rows [16];
   logic                      tape_in;
   logic signed [15:0]        ext_sound;
   logic [7:0]                ram_dout;
   logic [7:0]                cpu_din;
   logic                      wait_n;
   msx_bus_pkg::mem_port_t    mem;
   logic                      tape_motor_on;
   logic [15:0]               audio;

   logic [7:0] mem_model [mem_bytes];
   // Bytes the CPU has stored into RAM, keyed by memory address
   logic [7:0] written [int unsigned];
   logic [7:0] slot_shadow = '0;
   logic [7:0] ppi_c_shadow = '0;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;

   msx_top UUT (
      .clock_bus (clock_bus), .rst_n (rst_n), .cpu (cpu), .cpu_ce (cpu_ce),
      .slot_layout (slot_layout), .kbd_rows (kbd_rows), .tape_in (tape_in),
      .ext_sound (ext_sound), .ram_dout (ram_dout), .cpu_din (cpu_din),
      .wait_n (wait_n), .mem (mem), .tape_motor_on (tape_motor_on), .audio (audio)
   );

   initial begin
      clock_bus = 1'b0;
      forever #2 clock_bus = ~clock_bus;
   end

   // 3.58 MHz enable, every other clock
   always @(posedge clock_bus) cpu_ce <= rst_n && !cpu_ce;

   assign ram_dout = mem_model[mem.addr];

   always @(posedge clock_bus) begin
      if (cpu_ce && mem.ce && !mem.rnw)
         mem_model[mem.addr] <= mem.din;
   end

   always @(posedge clock_bus) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("Timeout: tests did not finish within %0d clock cycles", timeout_cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic logic [7:0] fill_byte(input int unsigned a);
      return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'h5A;
   endfunction

   function automatic logic [1:0] slot_of(input logic [15:0] addr);
      return slot_shadow[{addr[15:14], 1'b0} +: 2];
   endfunction

   // Bank times 16 KB plus the offset in the page
   function automatic int unsigned mem_loc(input logic [15:0] addr);
      return 32'(slot_layout[slot_of(addr)].bank) * 32'd16384 + 32'(addr[13:0]);
   endfunction

   function automatic logic [7:0] model_byte(input int unsigned loc);
      return written.exists(loc) ? written[loc] : fill_byte(loc);
   endfunction

   function automatic logic [7:0] read_expect(input logic [15:0] addr);
      if (slot_layout[slot_of(addr)].kind == msx_config_pkg::slot_empty)
         return 8'hFF;
      return model_byte(mem_loc(addr));
   endfunction

   // Sum within +-2^14 doubles, anything beyond clips
   function automatic logic [15:0] mix_expect(input logic signed [15:0] s, input logic beep,
                                              input logic tape, input logic motor);
      int total;
      total = int'(s);
      if (beep)
         total += msx_config_pkg::click_weight;
      if (tape && !motor)
         total += msx_config_pkg::tape_weight;
      if (total > 16383)
         return 16'h7FFF;
      if (total < -16384)
         return 16'h8000;
      return 16'(total * 2);
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // Start on the edge that opens a cycle with cpu_ce low
   task automatic align_to_ce();
      @(negedge clock_bus);
      while (!cpu_ce)
         @(negedge clock_bus);
      @(posedge clock_bus);
   endtask

   // Access held for two cpu_ce periods, then four idle clocks
   task automatic bus_access(input vec_op_t op, input logic [15:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata,
                             output int wait_clks);
      int i;
      wait_clks = 0;
      rdata = '0;
      align_to_ce();
      cpu.addr <= addr;
      cpu.dout <= wdata;
      cpu.mreq <= op inside {op_mem_wr, op_mem_rd, op_fetch};
      cpu.iorq <= op inside {op_io_wr, op_io_rd};
      cpu.rd   <= op inside {op_io_rd, op_mem_rd, op_fetch};
      cpu.wr   <= op inside {op_io_wr, op_mem_wr};
      cpu.m1   <= (op == op_fetch);
      for (i = 0; i < 8; i++) begin
         @(negedge clock_bus);
         if (i == 1)
            rdata = cpu_din;
         if (!wait_n)
            wait_clks++;
         if (i == 3) begin
            @(posedge clock_bus);
            cpu <= '0;
         end
      end
   endtask

   initial begin
      int unsigned        a;
      int unsigned        loc;
      int                 idx;
      int                 errs_before;
      int                 wait_clks;
      vec_t               v;
      vec_op_t            op;
      logic [7:0]         rdata;
      logic [7:0]         wdata;
      logic signed [15:0] sample;

      void'($urandom(32'hf385_891f));
      rst_n = 1'b0;
      cpu = '0;
      cpu_ce = 1'b0;
      tape_in = 1'b0;
      ext_sound = '0;
      slot_layout[0] = '{kind: msx_config_pkg::slot_empty, bank: 8'd0};
      slot_layout[1] = '{kind: msx_config_pkg::slot_ram, bank: 8'd5};
      slot_layout[2] = '{kind: msx_config_pkg::slot_rom, bank: 8'd9};
      slot_layout[3] = '{kind: msx_config_pkg::slot_empty, bank: 8'd2};
      for (idx = 0; idx < 16; idx++)
         kbd_rows[idx] = 8'hFF - 8'(idx * 17);
      for (a = 0; a < mem_bytes; a++)
         mem_model[a] = fill_byte(a);

      repeat (2) @(posedge clock_bus);
      rst_n <= 1'b1;
      @(negedge clock_bus);
      check_val("wait_n", 32'(wait_n), 32'd1);
      check_val("mem.ce", 32'(mem.ce), 32'd0);
      check_val("tape_motor_on", 32'(tape_motor_on), 32'd0);
      check_val("audio", 32'(audio), 32'd0);
      check_val("cpu_din", 32'(cpu_din), 32'hFF);
      $display("Test reset: %s", (errors == 0) ? "ok" : "failed");

      for (idx = 0; idx < num_vecs; idx++) begin
         v = vectors[idx];
         op = v.op;
         errs_before = errors;
         case (op)
            op_io_wr: begin
               bus_access(op, v.addr, v.data, rdata, wait_clks);
               // No read in progress, the bus idles high
               check_val("cpu_din", 32'(rdata), 32'hFF);
               if (v.addr[7:0] == msx_config_pkg::port_slot)
                  slot_shadow = v.data;
               if (v.addr[7:0] == msx_config_pkg::port_ppi_c) begin
                  ppi_c_shadow = v.data;
                  check_val("tape_motor_on", 32'(tape_motor_on),
                            32'(v.data[msx_config_pkg::motor_bit]));
               end
            end
            op_io_rd: begin
               bus_access(op, v.addr, 8'h00, rdata, wait_clks);
               check_val("cpu_din", 32'(rdata), 32'(v.exp));
            end
            op_mem_wr: begin
               wdata = 8'($urandom);
               loc = mem_loc(v.addr);
               bus_access(op, v.addr, wdata, rdata, wait_clks);
               check_val("cpu_din", 32'(rdata), 32'hFF);
               if (slot_layout[slot_of(v.addr)].kind == msx_config_pkg::slot_ram)
                  written[loc] = wdata;
               check_val("mem_model", 32'(mem_model[loc]), 32'(model_byte(loc)));
            end
            op_mem_rd, op_fetch: begin
               bus_access(op, v.addr, 8'h00, rdata, wait_clks);
               check_val("cpu_din", 32'(rdata), 32'(read_expect(v.addr)));
               check_val("wait_n low clocks", 32'(wait_clks),
                         (op == op_fetch) ? 32'(ce_period_clks) : 32'd0);
            end
            default: begin
               sample = (op == op_audio) ? v.addr : 16'($urandom);
               @(posedge clock_bus);
               ext_sound <= sample;
               tape_in <= v.data[0];
               @(posedge clock_bus);
               @(negedge clock_bus);
               check_val("audio", 32'(audio),
                         32'(mix_expect(sample, ppi_c_shadow[msx_config_pkg::click_bit],
                                        v.data[0], ppi_c_shadow[msx_config_pkg::motor_bit])));
            end
         endcase
         $display("Test %0d %s addr %h: %s", idx, op.name(), v.addr,
                  (errors == errs_before) ? "ok" : "failed");
      end

      $display("Summary: %0d tests, %0d checks, %0d errors", num_vecs + 1, checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* design/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer (
   input  logic               clock_bus,
   input  logic               rst_n,
   input  logic               keybeep,
   input  logic               tape_in,
   input  logic               tape_motor_on,
   input  logic signed [15:0] ext_sound,
   output logic [15:0]        audio
);

   localparam int w = msx_config_pkg::mix_w;

   logic [w-1:0] click_part;
   logic [w-1:0] tape_part;
   logic [w-1:0] sum;
   logic [15:0]  compr;

   assign click_part = keybeep ? w'(msx_config_pkg::click_weight) : '0;
   // Tape input is only heard while the motor is stopped
   assign tape_part  = (tape_in && !tape_motor_on) ? w'(msx_config_pkg::tape_weight) : '0;

   assign sum = {ext_sound[15], ext_sound} + click_part + tape_part;

   // Top three bits pick pass-through at double gain or a clip level
   always_comb begin
      case (sum[w-1:w-3])
         3'b000, 3'b111: compr = {sum[14:0], 1'b0};
         3'b001, 3'b010, 3'b011: compr = msx_config_pkg::audio_pos_max;
         default: compr = msx_config_pkg::audio_neg_max;
      endcase
   end

   always_ff @(posedge clock_bus) begin
      if (!rst_n)
         audio <= '0;
      else
         audio <= compr;
   end

endmodule

/* design/cpu_bus_control.sv */
`timescale 1ns/1ps

module cpu_bus_control (
   input  logic                   clock_bus,
   input  logic                   rst_n,
   input  msx_bus_pkg::cpu_pins_t cpu,
   input  logic                   cpu_ce,
   input  logic [7:0]             dev_data,
   input  logic                   dev_oe,
   input  logic [7:0]             slot_data,
   input  logic                   slot_oe,
   output msx_bus_pkg::bus_req_t  req,
   output logic                   wait_n,
   output logic [7:0]             cpu_din
);

   typedef enum logic [1:0] {
      wt_idle,
      wt_hold,
      wt_done
   } wait_state_t;

   msx_bus_pkg::cycle_kind_t kind;
   wait_state_t              wt_state;
   logic                     rd_cycle;

   // Opcode fetch takes precedence over a plain memory read
   always_comb begin
      kind = msx_bus_pkg::cyc_idle;
      if (cpu.mreq && cpu.rd && cpu.m1)
         kind = msx_bus_pkg::cyc_fetch;
      else if (cpu.mreq && cpu.rd)
         kind = msx_bus_pkg::cyc_mem_rd;
      else if (cpu.mreq && cpu.wr)
         kind = msx_bus_pkg::cyc_mem_wr;
      else if (cpu.iorq && cpu.rd)
         kind = msx_bus_pkg::cyc_io_rd;
      else if (cpu.iorq && cpu.wr)
         kind = msx_bus_pkg::cyc_io_wr;
   end

   assign req.kind   = kind;
   assign req.addr   = cpu.addr;
   assign req.wdata  = cpu.dout;
   assign req.strobe = cpu_ce && (kind != msx_bus_pkg::cyc_idle);

   // One wait period per M1, then hold off until m1 drops
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         wt_state <= wt_idle;
      end else if (cpu_ce) begin
         case (wt_state)
            wt_idle: if (cpu.m1) wt_state <= wt_hold;
            wt_hold: wt_state <= cpu.m1 ? wt_done : wt_idle;
            wt_done: if (!cpu.m1) wt_state <= wt_idle;
            default: wt_state <= wt_idle;
         endcase
      end
   end

   assign wait_n = (wt_state != wt_hold);

   assign rd_cycle = (kind == msx_bus_pkg::cyc_fetch) ||
                     (kind == msx_bus_pkg::cyc_mem_rd) ||
                     (kind == msx_bus_pkg::cyc_io_rd);

   // Devices first, then slots, else the idle bus value
   assign cpu_din = !rd_cycle ? msx_bus_pkg::bus_idle_data :
                    dev_oe    ? dev_data :
                    slot_oe   ? slot_data :
                                msx_bus_pkg::bus_idle_data;

   // Wait never outlasts a single cpu_ce period
   a_wait_single: assert property (@(posedge clock_bus) disable iff (!rst_n)
      (!wait_n && cpu_ce) |=> wait_n);

   // The CPU never opens both address spaces at once
   a_one_space: assert property (@(posedge clock_bus) disable iff (!rst_n)
      !(cpu.mreq && cpu.iorq));

   // Nor reads and writes in the same cycle
   a_one_dir: assert property (@(posedge clock_bus) disable iff (!rst_n)
      !(cpu.rd && cpu.wr));

endmodule

/* design/msx_bus_pkg.sv */
package msx_bus_pkg;

   // External memory is 4 MB, byte wide
   localparam int ram_addr_w = 22;

   // Value seen on an undriven data bus
   localparam logic [7:0] bus_idle_data = 8'hFF;

   // Raw Z80 outputs, strobes taken as active high
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        mreq;
      logic        iorq;
      logic        rd;
      logic        wr;
      logic        m1;
   } cpu_pins_t;

   // Kind of bus access seen on the pins
   typedef enum logic [2:0] {
      cyc_idle,
      cyc_fetch,
      cyc_mem_rd,
      cyc_mem_wr,
      cyc_io_rd,
      cyc_io_wr
   } cycle_kind_t;

   // Decoded access, strobe marks the cpu_ce cycle
   typedef struct packed {
      cycle_kind_t kind;
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        strobe;
   } bus_req_t;

   // Request toward external memory
   typedef struct packed {
      logic [ram_addr_w-1:0] addr;
      logic [7:0]            din;
      logic                  ce;
      logic                  rnw;
   } mem_port_t;

endpackage

/* design/msx_config_pkg.sv */
package msx_config_pkg;

   // What sits behind a primary slot
   typedef enum logic [1:0] {
      slot_empty,
      slot_rom,
      slot_ram
   } slot_kind_t;

   // One primary slot, bank counted in 16 KB units
   typedef struct packed {
      slot_kind_t kind;
      logic [7:0] bank;
   } slot_cfg_t;

   // System I/O ports
   localparam logic [7:0] port_slot  = 8'hA8;
   localparam logic [7:0] port_kbd   = 8'hA9;
   localparam logic [7:0] port_ppi_c = 8'hAA;

   // Port C bit positions
   localparam int click_bit = 7;
   localparam int motor_bit = 4;

   // Keyboard row select field in port C
   localparam int row_sel_lsb = 0;
   localparam int row_sel_w   = 4;

   // Levels added to the mix by the internal sources
   localparam int click_weight = 512;
   localparam int tape_weight  = 256;

   // Width of the mixing sum, one bit over the output
   localparam int mix_w = 17;

   // Clipping levels of the audio output
   localparam logic [15:0] audio_pos_max = 16'h7FFF;
   localparam logic [15:0] audio_neg_max = 16'h8000;

endpackage

/* design/msx_top.sv */
`timescale 1ns/1ps

module msx_top (
   input  logic                      clock_bus,
   input  logic                      rst_n,
   input  msx_bus_pkg::cpu_pins_t    cpu,
   input  logic                      cpu_ce,
   input  msx_config_pkg::slot_cfg_t slot_layout [4],
   input  logic [7:0]                kbd_rows [16],
   input  logic                      tape_in,
   input  logic signed [15:0]        ext_sound,
   input  logic [7:0]                ram_dout,
   output logic [7:0]                cpu_din,
   output logic                      wait_n,
   output msx_bus_pkg::mem_port_t    mem,
   output logic                      tape_motor_on,
   output logic [15:0]               audio
);

   msx_bus_pkg::bus_req_t req;
   logic [7:0]            dev_data;
   logic                  dev_oe;
   logic [7:0]            slot_data;
   logic                  slot_oe;
   logic [7:0]            slot_config;
   logic                  keybeep;

   cpu_bus_control u_bus (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .cpu       (cpu),
      .cpu_ce    (cpu_ce),
      .dev_data  (dev_data),
      .dev_oe    (dev_oe),
      .slot_data (slot_data),
      .slot_oe   (slot_oe),
      .req       (req),
      .wait_n    (wait_n),
      .cpu_din   (cpu_din)
   );

   system_devices u_devices (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .req           (req),
      .kbd_rows      (kbd_rows),
      .dev_data      (dev_data),
      .dev_oe        (dev_oe),
      .slot_config   (slot_config),
      .keybeep       (keybeep),
      .tape_motor_on (tape_motor_on)
   );

   slot_mapper u_slots (
      .req         (req),
      .slot_config (slot_config),
      .slot_layout (slot_layout),
      .ram_dout    (ram_dout),
      .slot_data   (slot_data),
      .slot_oe     (slot_oe),
      .mem         (mem)
   );

   audio_mixer u_mixer (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .keybeep       (keybeep),
      .tape_in       (tape_in),
      .tape_motor_on (tape_motor_on),
      .ext_sound     (ext_sound),
      .audio         (audio)
   );

endmodule

/* design/slot_mapper.sv */
`timescale 1ns/1ps

module slot_mapper (
   input  msx_bus_pkg::bus_req_t     req,
   input  logic [7:0]                slot_config,
   input  msx_config_pkg::slot_cfg_t slot_layout [4],
   input  logic [7:0]                ram_dout,
   output logic [7:0]                slot_data,
   output logic                      slot_oe,
   output msx_bus_pkg::mem_port_t    mem
);

   logic [1:0]                page;
   logic [1:0]                active_slot;
   msx_config_pkg::slot_cfg_t cfg;
   logic                      mem_rd;
   logic                      mem_wr;
   logic                      populated;
   logic                      writable;

   assign page = req.addr[15:14];

   // Two bits of slot_config per 16 KB page
   always_comb begin
      case (page)
         2'd0:    active_slot = slot_config[1:0];
         2'd1:    active_slot = slot_config[3:2];
         2'd2:    active_slot = slot_config[5:4];
         default: active_slot = slot_config[7:6];
      endcase
   end

   assign cfg = slot_layout[active_slot];

   assign mem_rd = (req.kind == msx_bus_pkg::cyc_fetch) ||
                   (req.kind == msx_bus_pkg::cyc_mem_rd);
   assign mem_wr = (req.kind == msx_bus_pkg::cyc_mem_wr);

   assign populated = (cfg.kind != msx_config_pkg::slot_empty);
   assign writable  = (cfg.kind == msx_config_pkg::slot_ram);

   always_comb begin
      // Bank picks the 16 KB block, page offset below it
      mem.addr = {cfg.bank, req.addr[13:0]};
      mem.din  = req.wdata;
      mem.ce   = (populated && mem_rd) || (writable && mem_wr);
      // Writes to ROM or empty slots never reach memory
      mem.rnw  = !(writable && mem_wr);
   end

   assign slot_oe   = populated && mem_rd;
   assign slot_data = ram_dout;

endmodule

/* design/system_devices.sv */
`timescale 1ns/1ps

module system_devices (
   input  logic                  clock_bus,
   input  logic                  rst_n,
   input  msx_bus_pkg::bus_req_t req,
   input  logic [7:0]            kbd_rows [16],
   output logic [7:0]            dev_data,
   output logic                  dev_oe,
   output logic [7:0]            slot_config,
   output logic                  keybeep,
   output logic                  tape_motor_on
);

   logic [7:0] slot_reg;
   logic [7:0] ppi_c;
   logic [7:0] port;
   logic       io_wr;
   logic       io_rd;
   logic [msx_config_pkg::row_sel_w-1:0] row_sel;

   assign port  = req.addr[7:0];
   assign io_wr = req.strobe && (req.kind == msx_bus_pkg::cyc_io_wr);
   assign io_rd = (req.kind == msx_bus_pkg::cyc_io_rd);

   // Primary slot select register, port A8
   always_ff @(posedge clock_bus) begin
      if (!rst_n)
         slot_reg <= '0;
      else if (io_wr && port == msx_config_pkg::port_slot)
         slot_reg <= req.wdata;
   end

   // Port C, keyboard row, motor and click bits
   always_ff @(posedge clock_bus) begin
      if (!rst_n)
         ppi_c <= '0;
      else if (io_wr && port == msx_config_pkg::port_ppi_c)
         ppi_c <= req.wdata;
   end

   assign row_sel = ppi_c[msx_config_pkg::row_sel_lsb +: msx_config_pkg::row_sel_w];

   always_comb begin
      dev_data = msx_bus_pkg::bus_idle_data;
      dev_oe   = 1'b0;
      if (io_rd) begin
         case (port)
            msx_config_pkg::port_slot: begin
               dev_data = slot_reg;
               dev_oe   = 1'b1;
            end
            msx_config_pkg::port_kbd: begin
               // Rows come in active low, passed through as is
               dev_data = kbd_rows[row_sel];
               dev_oe   = 1'b1;
            end
            msx_config_pkg::port_ppi_c: begin
               dev_data = ppi_c;
               dev_oe   = 1'b1;
            end
            default: begin
               dev_data = msx_bus_pkg::bus_idle_data;
               dev_oe   = 1'b0;
            end
         endcase
      end
   end

   assign slot_config   = slot_reg;
   assign keybeep       = ppi_c[msx_config_pkg::click_bit];
   assign tape_motor_on = ppi_c[msx_config_pkg::motor_bit];

endmodule

/* msx_top.f */
+incdir+bench
design/msx_bus_pkg.sv
design/msx_config_pkg.sv
design/cpu_bus_control.sv
design/system_devices.sv
design/slot_mapper.sv
design/audio_mixer.sv
design/msx_top.sv
bench/msx_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module msx_top_tb -f msx_top.f -o msx_sim \
   && ./obj_dir/msx_sim > sim.log 2>&1 \
   || echo "Build or simulation run failed"

cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log 2>/dev/null && exit 0 || exit 1
